/* hdl/ec_pkg.sv */
`default_nettype none

package ec_pkg;

  localparam int FE_W = 256;                  // Field element width

  typedef logic [FE_W-1:0] fe_t;              // Unsigned field element

  // secp256k1 prime, 2^256 - 2^32 - 977
  localparam fe_t SECP256K1_P =
    256'hFFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFF_FFFFFFFE_FFFFFC2F;

  typedef logic [4:0] eq_tag_t;               // Equation number 0..23

  // Point add classes, set by decode
  typedef enum logic [2:0] {
    CASE_GENERIC,
    CASE_P1_INF,
    CASE_P2_INF,
    CASE_OPPOSITE,
    CASE_DOUBLE
  } add_case_e;

  typedef enum logic [1:0] {IDLE, RUN, DONE} exec_state_e;   // Execute FSM

  typedef enum logic {MULT_IDLE, MULT_BUSY} mult_state_e;    // Multiplier FSM

endpackage

`default_nettype wire

/* hdl/ec_mod_mult.sv */
`default_nettype none

module ec_mod_mult
  import ec_pkg::*;
#(
  parameter fe_t FIELD_P = SECP256K1_P
) (
  input  logic    i_clk,
  input  logic    i_rst,
  input  logic    i_val,
  output logic    o_rdy,
  input  fe_t     i_a,       // Both operands below FIELD_P
  input  fe_t     i_b,
  input  eq_tag_t i_tag,
  output logic    o_val,
  output fe_t     o_dat,
  output eq_tag_t o_tag
);

  localparam int CNT_W = $clog2(FE_W);

  mult_state_e      state_q;
  logic [CNT_W-1:0] cnt_q;           // Bits of b still to scan
  fe_t              a_q, b_q, acc_q;
  logic [FE_W:0]    dbl_w, dbl_sub, add_w, add_sub;
  fe_t              dbl_r, step_w;

  assign o_rdy = (state_q == MULT_IDLE);

  // One step: acc = 2*acc + b[msb]*a, reduced twice
  assign dbl_w   = {acc_q, 1'b0};
  assign dbl_sub = dbl_w - {1'b0, FIELD_P};
  assign dbl_r   = dbl_sub[FE_W] ? dbl_w[FE_W-1:0] : dbl_sub[FE_W-1:0];  // Borrow means below p
  assign add_w   = {1'b0, dbl_r} + (b_q[FE_W-1] ? {1'b0, a_q} : '0);
  assign add_sub = add_w - {1'b0, FIELD_P};
  assign step_w  = add_sub[FE_W] ? add_w[FE_W-1:0] : add_sub[FE_W-1:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= MULT_IDLE;
      o_val   <= 1'b0;
    end else begin
      o_val <= 1'b0;
      case (state_q)
        MULT_IDLE: if (i_val) state_q <= MULT_BUSY;
        MULT_BUSY: begin
          if (cnt_q == '0) begin       // Last bit, product ready next cycle
            state_q <= MULT_IDLE;
            o_val   <= 1'b1;
          end
        end
        default: state_q <= MULT_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_rdy && i_val) begin
      a_q   <= i_a;
      b_q   <= i_b;
      o_tag <= i_tag;                  // Tag rides along unchanged
      acc_q <= '0;
      cnt_q <= CNT_W'(FE_W - 1);
    end else if (state_q == MULT_BUSY) begin
      acc_q <= step_w;
      b_q   <= {b_q[FE_W-2:0], 1'b0};  // Next bit to msb
      cnt_q <= cnt_q - 1'b1;
      if (cnt_q == '0) o_dat <= step_w;
    end
  end

  a_val_pulse: assert property (@(posedge i_clk) disable iff (i_rst) o_val |=> !o_val);

endmodule

`default_nettype wire

/* hdl/ec_add_decode.sv */
`default_nettype none

module ec_add_decode
  import ec_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  fe_t       i_p1_x,
  input  fe_t       i_p1_y,
  input  fe_t       i_p1_z,
  input  fe_t       i_p2_x,
  input  fe_t       i_p2_y,
  input  fe_t       i_p2_z,
  input  logic      i_val,
  output logic      o_rdy,
  input  logic      i_busy,      // Execute running or result pending
  output logic      o_go,
  output add_case_e o_case,
  output fe_t       o_p1_x,
  output fe_t       o_p1_y,
  output fe_t       o_p1_z,
  output fe_t       o_p2_x,
  output fe_t       o_p2_y,
  output fe_t       o_p2_z
);

  logic      xfer;
  add_case_e case_w;

  assign xfer = i_val && o_rdy;

  // Infinity wins over everything, then opposite, then doubling
  always_comb begin
    if (i_p1_z == '0)                             case_w = CASE_P1_INF;
    else if (i_p2_z == '0)                        case_w = CASE_P2_INF;
    else if (i_p1_x == i_p2_x && i_p1_y != i_p2_y) case_w = CASE_OPPOSITE;
    else if (i_p1_x == i_p2_x)                    case_w = CASE_DOUBLE;
    else                                          case_w = CASE_GENERIC;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_rdy <= 1'b0;
      o_go  <= 1'b0;
    end else begin
      o_go  <= xfer;                              // Single pulse per pair
      // Low from acceptance until busy takes over, then until output taken
      o_rdy <= !(xfer || o_go || i_busy);
    end
  end

  // Pair and class held for execute and result
  always_ff @(posedge i_clk) begin
    if (xfer) begin
      o_case <= case_w;
      o_p1_x <= i_p1_x;
      o_p1_y <= i_p1_y;
      o_p1_z <= i_p1_z;
      o_p2_x <= i_p2_x;
      o_p2_y <= i_p2_y;
      o_p2_z <= i_p2_z;
    end
  end

  a_go_pulse: assert property (@(posedge i_clk) disable iff (i_rst) o_go |=> !o_go);

endmodule

`default_nettype wire

/* hdl/ec_point_add.sv */
`default_nettype none

module ec_point_add
  import ec_pkg::*;
#(
  parameter fe_t FIELD_P = SECP256K1_P
) (
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_go,
  input  add_case_e i_case,
  input  fe_t       i_p1_x,
  input  fe_t       i_p1_y,
  input  fe_t       i_p1_z,
  input  fe_t       i_p2_x,
  input  fe_t       i_p2_y,
  input  fe_t       i_p2_z,
  output logic      o_busy,
  output logic      o_mul_val,
  input  logic      i_mul_rdy,
  output fe_t       o_mul_a,
  output fe_t       o_mul_b,
  output eq_tag_t   o_mul_tag,
  input  logic      i_res_val,   // Product return, always accepted
  input  fe_t       i_res_dat,
  input  eq_tag_t   i_res_tag,
  output logic      o_done,
  output fe_t       o_x,
  output fe_t       o_y,
  output fe_t       o_z
);

  // Jacobian add, registers reused as in the equation list
  //   U1 = X1*Z2^2, U2 = X2*Z1^2, S1 = Y1*Z2^3, S2 = Y2*Z1^3, H = U2-U1, R = S2-S1
  //   X3 = R^2 - H^3 - 2*U1*H^2
  //   Y3 = R*(U1*H^2 - X3) - S1*H^3
  //   Z3 = H*Z1*Z2

  exec_state_e state_q;
  logic [23:0] eq_val, eq_wait;     // Result present / already issued
  fe_t         a_q, c_q;            // Temporaries A and C
  fe_t         p1x_q, p1y_q, p1z_q, p2x_q, p2y_q, p2z_q;
  logic        run, can_issue, issue;
  logic        iss_en;
  eq_tag_t     iss_tag;
  fe_t         iss_a, iss_b;
  logic        op8, op9, op13, op15, op16, op17, op18, op21;

  // a - b mod p, wraps correctly in FE_W bits
  function automatic fe_t sub_mod(input fe_t a, input fe_t b);
    return a + ((b > a) ? FIELD_P : '0) - b;
  endfunction

  // 2*a mod p
  function automatic fe_t dbl_mod(input fe_t a);
    logic [FE_W:0] d;
    d = {a, 1'b0};
    if (d >= {1'b0, FIELD_P}) d = d - {1'b0, FIELD_P};
    return d[FE_W-1:0];
  endfunction

  assign run       = (state_q == RUN);
  assign o_busy    = (state_q != IDLE);
  assign o_done    = (state_q == DONE);        // One cycle in DONE
  assign can_issue = !o_mul_val || i_mul_rdy;
  assign issue     = run && iss_en && can_issue;

  // Multiply pick, first ready equation in the fixed order
  always_comb begin
    iss_en  = 1'b1;
    iss_tag = 5'd0;
    iss_a   = p2z_q;
    iss_b   = p2z_q;
    if (!eq_wait[0]) begin                                    // A = Z2^2
      iss_tag = 5'd0;  iss_a = p2z_q; iss_b = p2z_q;
    end else if (eq_val[0] && !eq_wait[1]) begin              // U1
      iss_tag = 5'd1;  iss_a = a_q;   iss_b = p1x_q;
    end else if (!eq_wait[2]) begin                           // C = Z1^2
      iss_tag = 5'd2;  iss_a = p1z_q; iss_b = p1z_q;
    end else if (eq_val[2] && !eq_wait[3]) begin              // U2
      iss_tag = 5'd3;  iss_a = c_q;   iss_b = p2x_q;
    end else if (eq_val[1] && !eq_wait[4]) begin              // Z2^3
      iss_tag = 5'd4;  iss_a = a_q;   iss_b = p2z_q;
    end else if (eq_val[4] && !eq_wait[5]) begin              // S1
      iss_tag = 5'd5;  iss_a = a_q;   iss_b = p1y_q;
    end else if (eq_val[3] && !eq_wait[6]) begin              // Z1^3
      iss_tag = 5'd6;  iss_a = c_q;   iss_b = p1z_q;
    end else if (eq_val[6] && !eq_wait[7]) begin              // S2
      iss_tag = 5'd7;  iss_a = c_q;   iss_b = p2y_q;
    end else if (eq_val[9] && !eq_wait[10]) begin             // R^2
      iss_tag = 5'd10; iss_a = p2y_q; iss_b = p2y_q;
    end else if (eq_val[9] && !eq_wait[11]) begin             // H^2
      iss_tag = 5'd11; iss_a = p1y_q; iss_b = p1y_q;
    end else if (eq_val[11] && eq_val[8] && !eq_wait[12]) begin   // H^3
      iss_tag = 5'd12; iss_a = c_q;   iss_b = p1y_q;
    end else if (eq_val[11] && eq_val[8] && !eq_wait[14]) begin   // U1*H^2
      iss_tag = 5'd14; iss_a = c_q;   iss_b = p1x_q;
    end else if (eq_val[18] && eq_val[9] && !eq_wait[19]) begin   // R*(U1*H^2 - X3)
      iss_tag = 5'd19; iss_a = o_y;   iss_b = p2y_q;
    end else if (eq_val[5] && eq_val[12] && !eq_wait[20]) begin   // S1*H^3
      iss_tag = 5'd20; iss_a = p2x_q; iss_b = a_q;
    end else if (!eq_wait[22]) begin                          // Z1*Z2
      iss_tag = 5'd22; iss_a = p1z_q; iss_b = p2z_q;
    end else if (eq_val[8] && eq_val[22] && !eq_wait[23]) begin   // Z3
      iss_tag = 5'd23; iss_a = o_z;   iss_b = p1y_q;
    end else begin
      iss_en  = 1'b0;
    end
  end

  // In-module steps
  assign op8  = run && eq_val[1] && eq_val[3] && eq_val[5] && !eq_wait[8];   // H
  assign op9  = run && eq_val[5] && eq_val[7] && !eq_wait[9];                // R
  assign op13 = run && eq_val[12] && eq_val[10] && !eq_wait[13];             // R^2 - H^3
  assign op15 = run && eq_val[14] && !eq_wait[15];                           // Copy U1*H^2
  assign op16 = run && eq_val[15] && eq_val[14] && !eq_wait[16];             // 2*U1*H^2
  assign op17 = run && eq_val[16] && eq_val[13] && !eq_wait[17];             // X3
  assign op18 = run && eq_val[17] && eq_val[15] && !eq_wait[18];
  assign op21 = run && eq_val[20] && eq_val[19] && !eq_wait[21];             // Y3

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q   <= IDLE;
      eq_val    <= '0;
      eq_wait   <= '0;
      o_mul_val <= 1'b0;
    end else begin
      if (o_mul_val && i_mul_rdy) o_mul_val <= 1'b0;   // Request taken
      case (state_q)
        IDLE: begin
          eq_val  <= '0;
          eq_wait <= '0;
          if (i_go && i_case == CASE_GENERIC) state_q <= RUN;   // Others bypass
        end
        RUN: begin
          if (issue) begin
            o_mul_val        <= 1'b1;
            eq_wait[iss_tag] <= 1'b1;
          end
          if (i_res_val) eq_val[i_res_tag] <= 1'b1;
          if (op8)  begin eq_wait[8]  <= 1'b1; eq_val[8]  <= 1'b1; end
          if (op9)  begin eq_wait[9]  <= 1'b1; eq_val[9]  <= 1'b1; end
          if (op13) begin eq_wait[13] <= 1'b1; eq_val[13] <= 1'b1; end
          if (op15) begin eq_wait[15] <= 1'b1; eq_val[15] <= 1'b1; end
          if (op16) begin eq_wait[16] <= 1'b1; eq_val[16] <= 1'b1; end
          if (op17) begin eq_wait[17] <= 1'b1; eq_val[17] <= 1'b1; end
          if (op18) begin eq_wait[18] <= 1'b1; eq_val[18] <= 1'b1; end
          if (op21) begin eq_wait[21] <= 1'b1; eq_val[21] <= 1'b1; end
          if (&eq_val) state_q <= DONE;                 // All 24 results in
        end
        DONE:    state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge i_clk) begin
    if (state_q == IDLE && i_go) begin
      p1x_q <= i_p1_x;
      p1y_q <= i_p1_y;
      p1z_q <= i_p1_z;
      p2x_q <= i_p2_x;
      p2y_q <= i_p2_y;
      p2z_q <= i_p2_z;
    end
    if (issue) begin
      o_mul_a   <= iss_a;
      o_mul_b   <= iss_b;
      o_mul_tag <= iss_tag;
    end
    if (i_res_val) begin
      case (i_res_tag)
        5'd0, 5'd4, 5'd5:        a_q   <= i_res_dat;
        5'd2, 5'd6, 5'd7, 5'd11: c_q   <= i_res_dat;
        5'd1, 5'd14:             p1x_q <= i_res_dat;
        5'd3, 5'd12, 5'd20:      p2x_q <= i_res_dat;
        5'd10:                   o_x   <= i_res_dat;
        5'd19:                   o_y   <= i_res_dat;
        5'd22, 5'd23:            o_z   <= i_res_dat;
        default: ;
      endcase
    end
    if (op8)  p1y_q <= sub_mod(p2x_q, p1x_q);
    if (op9)  p2y_q <= sub_mod(c_q, a_q);
    if (op13) o_x   <= sub_mod(o_x, p2x_q);
    if (op15) o_y   <= p1x_q;
    if (op16) p1x_q <= dbl_mod(p1x_q);
    if (op17) o_x   <= sub_mod(o_x, p1x_q);
    if (op18) o_y   <= sub_mod(o_y, o_x);
    if (op21) o_y   <= sub_mod(o_y, p2x_q);
  end

  a_tag_waited: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val |-> eq_wait[i_res_tag]);
  a_tag_fresh: assert property (@(posedge i_clk) disable iff (i_rst)
    i_res_val |-> !eq_val[i_res_tag]);

endmodule

`default_nettype wire

/* hdl/ec_add_result.sv */
`default_nettype none

module ec_add_result
  import ec_pkg::*;
(
  input  logic      i_clk,
  input  logic      i_rst,
  input  logic      i_dec_go,
  input  add_case_e i_case,
  input  fe_t       i_p1_x,
  input  fe_t       i_p1_y,
  input  fe_t       i_p1_z,
  input  fe_t       i_p2_x,
  input  fe_t       i_p2_y,
  input  fe_t       i_p2_z,
  input  logic      i_exe_done,
  input  fe_t       i_x,
  input  fe_t       i_y,
  input  fe_t       i_z,
  output fe_t       o_p_x,
  output fe_t       o_p_y,
  output fe_t       o_p_z,
  output logic      o_err,
  output logic      o_val,
  input  logic      i_rdy
);

  logic load_dec;

  assign load_dec = i_dec_go && (i_case != CASE_GENERIC);   // Generic waits for execute

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end else if (load_dec || i_exe_done) begin
      o_val <= 1'b1;
      o_err <= load_dec && (i_case == CASE_DOUBLE);         // Doubling not supported
    end else if (o_val && i_rdy) begin
      o_val <= 1'b0;
      o_err <= 1'b0;
    end
  end

  // Point only changes on a new load, so it holds under back-pressure
  always_ff @(posedge i_clk) begin
    if (i_exe_done) begin
      o_p_x <= i_x;
      o_p_y <= i_y;
      o_p_z <= i_z;
    end else if (load_dec) begin
      case (i_case)
        CASE_P1_INF: begin o_p_x <= i_p2_x; o_p_y <= i_p2_y; o_p_z <= i_p2_z; end
        CASE_P2_INF: begin o_p_x <= i_p1_x; o_p_y <= i_p1_y; o_p_z <= i_p1_z; end
        default:     begin o_p_x <= '0;     o_p_y <= '0;     o_p_z <= '0;     end
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/ec_add_top.sv */
`default_nettype none

module ec_add_top
  import ec_pkg::*;
#(
  parameter fe_t FIELD_P = SECP256K1_P
) (
  input  logic i_clk,
  input  logic i_rst,
  input  fe_t  i_p1_x,
  input  fe_t  i_p1_y,
  input  fe_t  i_p1_z,
  input  fe_t  i_p2_x,
  input  fe_t  i_p2_y,
  input  fe_t  i_p2_z,
  input  logic i_val,
  output logic o_rdy,
  output fe_t  o_p_x,
  output fe_t  o_p_y,
  output fe_t  o_p_z,
  output logic o_err,
  output logic o_val,
  input  logic i_rdy
);

  logic      dec_go, exe_busy, dec_busy, exe_done;
  add_case_e dec_case;
  fe_t       p1_x, p1_y, p1_z, p2_x, p2_y, p2_z;
  fe_t       exe_x, exe_y, exe_z;
  logic      mul_val, mul_rdy, res_val;
  fe_t       mul_a, mul_b, res_dat;
  eq_tag_t   mul_tag, res_tag;

  assign dec_busy = exe_busy | o_val;   // One pair in flight at a time

  ec_add_decode i_ec_add_decode (
    .i_clk, .i_rst, .i_p1_x, .i_p1_y, .i_p1_z, .i_p2_x, .i_p2_y, .i_p2_z,
    .i_val, .o_rdy, .i_busy(dec_busy), .o_go(dec_go), .o_case(dec_case),
    .o_p1_x(p1_x), .o_p1_y(p1_y), .o_p1_z(p1_z),
    .o_p2_x(p2_x), .o_p2_y(p2_y), .o_p2_z(p2_z)
  );

  ec_point_add #(.FIELD_P(FIELD_P)) i_ec_point_add (
    .i_clk, .i_rst, .i_go(dec_go), .i_case(dec_case),
    .i_p1_x(p1_x), .i_p1_y(p1_y), .i_p1_z(p1_z),
    .i_p2_x(p2_x), .i_p2_y(p2_y), .i_p2_z(p2_z),
    .o_busy(exe_busy), .o_mul_val(mul_val), .i_mul_rdy(mul_rdy),
    .o_mul_a(mul_a), .o_mul_b(mul_b), .o_mul_tag(mul_tag),
    .i_res_val(res_val), .i_res_dat(res_dat), .i_res_tag(res_tag),
    .o_done(exe_done), .o_x(exe_x), .o_y(exe_y), .o_z(exe_z)
  );

  ec_mod_mult #(.FIELD_P(FIELD_P)) i_ec_mod_mult (
    .i_clk, .i_rst, .i_val(mul_val), .o_rdy(mul_rdy), .i_a(mul_a), .i_b(mul_b),
    .i_tag(mul_tag), .o_val(res_val), .o_dat(res_dat), .o_tag(res_tag)
  );

  ec_add_result i_ec_add_result (
    .i_clk, .i_rst, .i_dec_go(dec_go), .i_case(dec_case),
    .i_p1_x(p1_x), .i_p1_y(p1_y), .i_p1_z(p1_z),
    .i_p2_x(p2_x), .i_p2_y(p2_y), .i_p2_z(p2_z),
    .i_exe_done(exe_done), .i_x(exe_x), .i_y(exe_y), .i_z(exe_z),
    .o_p_x, .o_p_y, .o_p_z, .o_err, .o_val, .i_rdy
  );

endmodule

`default_nettype wire

/* sim/tb_ec_model.svh */
`ifndef TB_EC_MODEL_SVH
`define TB_EC_MODEL_SVH

  // Field arithmetic mod FIELD_P, operands already below FIELD_P
  function automatic fe_t mod_add(input fe_t a, input fe_t b);
    logic [FE_W:0] s;
    s = {1'b0, a} + {1'b0, b};
    if (s >= {1'b0, FIELD_P}) s = s - {1'b0, FIELD_P};
    return s[FE_W-1:0];
  endfunction

  function automatic fe_t mod_sub(input fe_t a, input fe_t b);
    logic [FE_W:0] d;
    d = {1'b0, a} + {1'b0, FIELD_P} - {1'b0, b};   // Never negative
    if (d >= {1'b0, FIELD_P}) d = d - {1'b0, FIELD_P};
    return d[FE_W-1:0];
  endfunction

  // Full double-width product, then one remainder
  function automatic fe_t mod_mul(input fe_t a, input fe_t b);
    logic [2*FE_W-1:0] prod;
    prod = {{FE_W{1'b0}}, a} * {{FE_W{1'b0}}, b};
    prod = prod % {{FE_W{1'b0}}, FIELD_P};
    return prod[FE_W-1:0];
  endfunction

  // Jacobian add, generic case only
  function automatic void jac_add(input fe_t x1, input fe_t y1, input fe_t z1,
                                  input fe_t x2, input fe_t y2, input fe_t z2,
                                  output fe_t x3, output fe_t y3, output fe_t z3);
    fe_t z1s, z2s, u1, u2, s1, s2, h, r, h2, h3, u1h2;
    z1s  = mod_mul(z1, z1);
    z2s  = mod_mul(z2, z2);
    u1   = mod_mul(x1, z2s);
    u2   = mod_mul(x2, z1s);
    s1   = mod_mul(y1, mod_mul(z2s, z2));           // Y1*Z2^3
    s2   = mod_mul(y2, mod_mul(z1s, z1));           // Y2*Z1^3
    h    = mod_sub(u2, u1);
    r    = mod_sub(s2, s1);
    h2   = mod_mul(h, h);
    h3   = mod_mul(h2, h);
    u1h2 = mod_mul(u1, h2);
    x3   = mod_sub(mod_sub(mod_mul(r, r), h3), mod_add(u1h2, u1h2));
    y3   = mod_sub(mod_mul(r, mod_sub(u1h2, x3)), mod_mul(s1, h3));
    z3   = mod_mul(mod_mul(h, z1), z2);
  endfunction

`endif

/* sim/tb_ec_add.sv */
`default_nettype none

module tb_ec_add
  import ec_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam fe_t FIELD_P    = SECP256K1_P;
  // 12 cases, 16 multiplies each, about 260 cycles per multiply, plus margin
  localparam int  MAX_CYCLES = 12 * 16 * 260 + 5080;

  logic        i_clk, i_rst, i_val, o_rdy, o_err, o_val, i_rdy;
  fe_t         i_p1_x, i_p1_y, i_p1_z, i_p2_x, i_p2_y, i_p2_z;
  fe_t         o_p_x, o_p_y, o_p_z;
  fe_t         exp_x, exp_y, exp_z;     // Expected point of the pair in flight
  logic        exp_err, in_flight;
  logic [15:0] lfsr;
  int          cycles;

  `include "tb_ec_model.svh"

  ec_add_top #(.FIELD_P(FIELD_P)) i_ec_add_top (
    .i_clk, .i_rst, .i_p1_x, .i_p1_y, .i_p1_z, .i_p2_x, .i_p2_y, .i_p2_z,
    .i_val, .o_rdy, .o_p_x, .o_p_y, .o_p_z, .o_err, .o_val, .i_rdy
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;       // 100 ns period
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_bit(output logic b);
    lfsr = lfsr_step(lfsr);
    b    = lfsr[0];
  endtask

  task automatic rand_fe(output fe_t v);
    logic b;
    v = '0;
    for (int i = 0; i < FE_W; i++) begin
      rand_bit(b);
      v = {v[FE_W-2:0], b};
    end
    if (v >= FIELD_P) v = v - FIELD_P;   // Keep it a field element
  endtask

  task automatic rand_pair(output fe_t x1, output fe_t y1, output fe_t z1,
                           output fe_t x2, output fe_t y2, output fe_t z2);
    rand_fe(x1);
    rand_fe(y1);
    rand_fe(z1);
    rand_fe(x2);
    rand_fe(y2);
    rand_fe(z2);
  endtask

  // Hold the pair on the inputs until decode takes it
  task automatic send_pair(input fe_t x1, input fe_t y1, input fe_t z1,
                           input fe_t x2, input fe_t y2, input fe_t z2);
    i_p1_x <= x1;
    i_p1_y <= y1;
    i_p1_z <= z1;
    i_p2_x <= x2;
    i_p2_y <= y2;
    i_p2_z <= z2;
    i_val  <= 1'b1;
    do @(posedge i_clk); while (!o_rdy);
    i_val  <= 1'b0;
  endtask

  // Random back-pressure until the output is taken
  task automatic collect_result();
    logic b;
    do begin
      rand_bit(b);
      i_rdy <= b;
      @(posedge i_clk);
    end while (!(o_val && i_rdy));
    i_rdy <= 1'b0;
  endtask

  task automatic run_case(input fe_t x1, input fe_t y1, input fe_t z1,
                          input fe_t x2, input fe_t y2, input fe_t z2);
    send_pair(x1, y1, z1, x2, y2, z2);
    collect_result();
  endtask

  initial begin
    fe_t x1, y1, z1, x2, y2, z2;
    i_rst  = 1'b1;
    i_val  = 1'b0;
    i_rdy  = 1'b0;
    i_p1_x = '0;
    i_p1_y = '0;
    i_p1_z = '0;
    i_p2_x = '0;
    i_p2_y = '0;
    i_p2_z = '0;
    lfsr   = 16'd80;
    repeat (3) @(posedge i_clk);
    i_rst <= 1'b0;
    rand_pair(x1, y1, z1, x2, y2, z2);
    run_case(x1, y1, '0, x2, y2, z2);                 // P1 at infinity
    rand_pair(x1, y1, z1, x2, y2, z2);
    run_case(x1, y1, z1, x2, y2, '0);                 // P2 at infinity
    rand_pair(x1, y1, z1, x2, y2, z2);
    run_case(x1, y1, z1, x1, mod_sub('0, y1), z1);    // Opposites
    rand_pair(x1, y1, z1, x2, y2, z2);
    run_case(x1, y1, z1, x1, y1, z1);                 // Doubling, rejected
    for (int n = 0; n < 8; n++) begin
      rand_pair(x1, y1, z1, x2, y2, z2);
      run_case(x1, y1, z1, x2, y2, z2);               // Generic
    end
    $display("All tests passed");
    $finish;
  end

  // Scoreboard, expected output per accepted pair
  always @(posedge i_clk) begin
    fe_t  ex, ey, ez;
    logic er;
    ex = '0;
    ey = '0;
    ez = '0;
    er = 1'b0;
    if (i_rst) begin
      in_flight <= 1'b0;
    end else if (i_val && o_rdy) begin
      in_flight <= 1'b1;
      if (i_p1_z == '0) begin
        ex = i_p2_x;
        ey = i_p2_y;
        ez = i_p2_z;
      end else if (i_p2_z == '0) begin
        ex = i_p1_x;
        ey = i_p1_y;
        ez = i_p1_z;
      end else if (i_p1_x == i_p2_x) begin
        er = (i_p1_y == i_p2_y);          // Equal points, else opposites at zero
      end else begin
        jac_add(i_p1_x, i_p1_y, i_p1_z, i_p2_x, i_p2_y, i_p2_z, ex, ey, ez);
      end
      exp_x   <= ex;
      exp_y   <= ey;
      exp_z   <= ez;
      exp_err <= er;
    end else if (o_val && i_rdy) begin
      in_flight <= 1'b0;
    end
  end

  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) fail_run($sformatf("Timeout after %0d cycles", MAX_CYCLES));
  end

  initial cycles = 0;

  a_out_x: assert property (@(posedge i_clk) disable iff (i_rst) (o_val && i_rdy) |-> o_p_x == exp_x)
    else fail_run($sformatf("FAILED o_p_x: got %h expected %h", $sampled(o_p_x), $sampled(exp_x)));
  a_out_y: assert property (@(posedge i_clk) disable iff (i_rst) (o_val && i_rdy) |-> o_p_y == exp_y)
    else fail_run($sformatf("FAILED o_p_y: got %h expected %h", $sampled(o_p_y), $sampled(exp_y)));
  a_out_z: assert property (@(posedge i_clk) disable iff (i_rst) (o_val && i_rdy) |-> o_p_z == exp_z)
    else fail_run($sformatf("FAILED o_p_z: got %h expected %h", $sampled(o_p_z), $sampled(exp_z)));
  a_out_err: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && i_rdy) |-> o_err == exp_err)
    else fail_run($sformatf("FAILED o_err: got %h expected %h", $sampled(o_err), $sampled(exp_err)));

  // Special cases bypass execute, output two cycles after acceptance
  a_fast_case: assert property (@(posedge i_clk) disable iff (i_rst)
    (i_val && o_rdy && (i_p1_z == '0 || i_p2_z == '0 || i_p1_x == i_p2_x)) |-> ##2 o_val)
    else fail_run("o_val did not rise two cycles after a special-case pair was accepted");

  a_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_val && !i_rdy) |=> (o_val && $stable(o_p_x) && $stable(o_p_y) && $stable(o_p_z)
                           && $stable(o_err)))
    else fail_run("Output changed or dropped while o_val was high and i_rdy was low");

  a_one_pair: assert property (@(posedge i_clk) disable iff (i_rst) in_flight |-> !o_rdy)
    else fail_run("o_rdy went high before the previous result was taken");

endmodule

`default_nettype wire

/* files.f */
+incdir+sim
hdl/ec_pkg.sv
hdl/ec_mod_mult.sv
hdl/ec_add_decode.sv
hdl/ec_point_add.sv
hdl/ec_add_result.sv
hdl/ec_add_top.sv
sim/tb_ec_add.sv

/* Bender.yml */
package:
  name: ec_add

sources:
  - files:
      - hdl/ec_pkg.sv
      - hdl/ec_mod_mult.sv
      - hdl/ec_add_decode.sv
      - hdl/ec_point_add.sv
      - hdl/ec_add_result.sv
      - hdl/ec_add_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_ec_add.sv
